/* verilog/refr_macros.svh */
`ifndef REFR_MACROS_SVH
`define REFR_MACROS_SVH

// memory macro geometry.
`define REFR_NUMRBNK 8
`define REFR_BITRBNK 3
`define REFR_NUMRROW 16
`define REFR_BITRROW 4

// refresh period in clock cycles, three at the least so that the
// two scheduler stages can drain between pulses.
`define REFR_REFFREQ 10

`endif

/* verilog/refr_pkg.sv */
`include "refr_macros.svh"

package refr_pkg;

  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } acc_op_t;

  typedef struct packed {
    acc_op_t                  op;
    logic [`REFR_BITRBNK-1:0] bank;
    logic [`REFR_BITRROW-1:0] row;
  } acc_req_t;

  typedef struct packed {
    logic     valid;
    acc_req_t req;
  } mem_acc_t;

  typedef struct packed {
    logic                     valid;
    logic [`REFR_BITRBNK-1:0] bank;
    logic [`REFR_BITRROW-1:0] row;
  } refr_cmd_t;

  typedef enum logic [0:0] {
    SLOT_EMPTY = 1'b0,
    SLOT_BUSY  = 1'b1
  } slot_state_t;

endpackage

/* verilog/refr_tick_gen.sv */
`timescale 1ns/1ps
`include "refr_macros.svh"

module refr_tick_gen (
  input  logic clk,
  input  logic rst,
  output logic pref
);

  localparam int CW = $clog2(`REFR_REFFREQ);
  localparam logic [CW-1:0] RELOAD = CW'(`REFR_REFFREQ - 1);

  logic [CW-1:0] cnt;

  if (`REFR_REFFREQ < 3) begin : g_period_check
    $error("refresh period must be at least 3 cycles");
  end

  // the counter sits at the reload value during reset, so the first pulse
  // lands on the last cycle of the first full period.
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= RELOAD;
    end else if (cnt == '0) begin
      cnt <= RELOAD;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  assign pref = (cnt == '0);

  a_pref_single: assert property (@(posedge clk) disable iff (rst)
    pref |=> !pref);

  a_pref_period: assert property (@(posedge clk) disable iff (rst)
    !pref |-> ##[1:`REFR_REFFREQ-1] pref);

endmodule

/* verilog/refr_access_gate.sv */
`timescale 1ns/1ps

module refr_access_gate (
  input  logic               clk,
  input  logic               rst,
  input  logic               pref,
  input  refr_pkg::acc_req_t acc1_req,
  input  logic               acc1_valid,
  output logic               acc1_ready,
  input  refr_pkg::acc_req_t acc2_req,
  input  logic               acc2_valid,
  output logic               acc2_ready,
  output refr_pkg::mem_acc_t mem_acc1,
  output refr_pkg::mem_acc_t mem_acc2
);

  import refr_pkg::*;

  localparam int NPORT = 2;

  logic [NPORT-1:0] port_valid;
  logic [NPORT-1:0] fire;
  logic [NPORT-1:0] valid_q;
  acc_req_t         req_in [NPORT];
  acc_req_t         req_q  [NPORT];

  // both ports are held off for the single cycle a refresh starts.
  assign acc1_ready = ~pref;
  assign acc2_ready = ~pref;

  assign port_valid = {acc2_valid, acc1_valid};
  assign req_in[0]  = acc1_req;
  assign req_in[1]  = acc2_req;
  assign fire       = port_valid & {NPORT{~pref}};

  // ------------------------------------------------------------------------
  // handshake register
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= fire;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NPORT; i++) begin
      if (fire[i]) begin
        req_q[i] <= req_in[i];
      end
    end
  end

  assign mem_acc1 = '{valid: valid_q[0], req: req_q[0]};
  assign mem_acc2 = '{valid: valid_q[1], req: req_q[1]};

  // an access never reaches the memory right behind a refresh start.
  a_no_acc_on_pref: assert property (@(posedge clk) disable iff (rst)
    pref |=> !(mem_acc1.valid || mem_acc2.valid));

endmodule

/* verilog/refr_sched.sv */
`timescale 1ns/1ps
`include "refr_macros.svh"

module refr_sched (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     pref,
  input  refr_pkg::mem_acc_t       mem_acc1,
  input  refr_pkg::mem_acc_t       mem_acc2,
  output logic                     prefr,
  output logic [`REFR_BITRBNK-1:0] prfbadr,
  output logic                     refr_overflow
);

  import refr_pkg::*;

  localparam logic [`REFR_BITRBNK-1:0] LAST_BANK = `REFR_BITRBNK'(`REFR_NUMRBNK - 1);

  slot_state_t              s0_state;
  slot_state_t              s1_state;
  logic [`REFR_BITRBNK-1:0] s0_bank;
  logic [`REFR_BITRBNK-1:0] s1_bank;
  logic [`REFR_BITRBNK-1:0] bank_ptr;
  logic                     s1_hit;
  logic                     issue;
  logic                     promote;
  logic                     load;
  logic                     drop;

  // ------------------------------------------------------------------------
  // issue and promotion
  // ------------------------------------------------------------------------

  // stage 1 waits while either registered access targets its bank.
  assign s1_hit = (mem_acc1.valid && (mem_acc1.req.bank == s1_bank)) ||
                  (mem_acc2.valid && (mem_acc2.req.bank == s1_bank));
  assign issue   = (s1_state == SLOT_BUSY) && !s1_hit;
  assign promote = (s0_state == SLOT_BUSY) && ((s1_state == SLOT_EMPTY) || issue);

  // stage 0 only frees up this cycle if it can move forward.
  assign drop = pref && (s0_state == SLOT_BUSY) && !promote;
  assign load = pref && !drop;

  assign prefr   = issue;
  assign prfbadr = s1_bank;

  always_ff @(posedge clk) begin
    if (rst) begin
      s0_state <= SLOT_EMPTY;
      s1_state <= SLOT_EMPTY;
    end else begin
      if (load) begin
        s0_state <= SLOT_BUSY;
      end else if (promote) begin
        s0_state <= SLOT_EMPTY;
      end
      if (promote) begin
        s1_state <= SLOT_BUSY;
      end else if (issue) begin
        s1_state <= SLOT_EMPTY;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      s0_bank <= bank_ptr;
    end
    if (promote) begin
      s1_bank <= s0_bank;
    end
  end

  // ------------------------------------------------------------------------
  // round-robin pointer and overflow
  // ------------------------------------------------------------------------

  // the pointer moves on every pulse so a dropped request leaves its bank out.
  always_ff @(posedge clk) begin
    if (rst) begin
      bank_ptr      <= '0;
      refr_overflow <= 1'b0;
    end else begin
      if (pref) begin
        bank_ptr <= (bank_ptr == LAST_BANK) ? '0 : bank_ptr + 1'b1;
      end
      if (drop) begin
        refr_overflow <= 1'b1;
      end
    end
  end

  a_stage_banks_differ: assert property (@(posedge clk) disable iff (rst)
    !((s0_state == SLOT_BUSY) && (s1_state == SLOT_BUSY) && (s0_bank == s1_bank)));

  a_prfbadr_range: assert property (@(posedge clk) disable iff (rst)
    prefr |-> (prfbadr < `REFR_NUMRBNK));

  a_no_bank_conflict: assert property (@(posedge clk) disable iff (rst)
    prefr |-> !(mem_acc1.valid && (mem_acc1.req.bank == prfbadr)) &&
              !(mem_acc2.valid && (mem_acc2.req.bank == prfbadr)));

endmodule

/* verilog/refr_row_track.sv */
`timescale 1ns/1ps
`include "refr_macros.svh"

module refr_row_track (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     prefr,
  input  logic [`REFR_BITRBNK-1:0] prfbadr,
  output refr_pkg::refr_cmd_t      mem_refr
);

  localparam logic [`REFR_BITRROW-1:0] LAST_ROW = `REFR_BITRROW'(`REFR_NUMRROW - 1);

  logic [`REFR_BITRROW-1:0] row_cnt [`REFR_NUMRBNK];
  logic                     valid_q;
  logic [`REFR_BITRBNK-1:0] bank_q;
  logic [`REFR_BITRROW-1:0] row_q;

  // ------------------------------------------------------------------------
  // per-bank row counters
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < `REFR_NUMRBNK; b++) begin
        row_cnt[b] <= '0;
      end
    end else if (prefr) begin
      row_cnt[prfbadr] <= (row_cnt[prfbadr] == LAST_ROW) ? '0 : row_cnt[prfbadr] + 1'b1;
    end
  end

  // the command carries the row before the increment.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= prefr;
    end
  end

  always_ff @(posedge clk) begin
    if (prefr) begin
      bank_q <= prfbadr;
      row_q  <= row_cnt[prfbadr];
    end
  end

  assign mem_refr = '{valid: valid_q, bank: bank_q, row: row_q};

  // back-to-back commands come from the two different scheduler stages.
  a_refr_b2b_bank: assert property (@(posedge clk) disable iff (rst)
    mem_refr.valid ##1 mem_refr.valid |-> (mem_refr.bank != $past(mem_refr.bank)));

endmodule

/* verilog/refr_top.sv */
`timescale 1ns/1ps
`include "refr_macros.svh"

module refr_top (
  input  logic                clk,
  input  logic                rst,
  input  refr_pkg::acc_req_t  acc1_req,
  input  logic                acc1_valid,
  output logic                acc1_ready,
  input  refr_pkg::acc_req_t  acc2_req,
  input  logic                acc2_valid,
  output logic                acc2_ready,
  output logic                pref,
  output refr_pkg::mem_acc_t  mem_acc1,
  output refr_pkg::mem_acc_t  mem_acc2,
  output refr_pkg::refr_cmd_t mem_refr,
  output logic                refr_overflow
);

  logic                     prefr;
  logic [`REFR_BITRBNK-1:0] prfbadr;

  refr_tick_gen u_tick_gen (
    .clk  (clk),
    .rst  (rst),
    .pref (pref)
  );

  refr_access_gate u_access_gate (
    .clk        (clk),
    .rst        (rst),
    .pref       (pref),
    .acc1_req   (acc1_req),
    .acc1_valid (acc1_valid),
    .acc1_ready (acc1_ready),
    .acc2_req   (acc2_req),
    .acc2_valid (acc2_valid),
    .acc2_ready (acc2_ready),
    .mem_acc1   (mem_acc1),
    .mem_acc2   (mem_acc2)
  );

  refr_sched u_sched (
    .clk           (clk),
    .rst           (rst),
    .pref          (pref),
    .mem_acc1      (mem_acc1),
    .mem_acc2      (mem_acc2),
    .prefr         (prefr),
    .prfbadr       (prfbadr),
    .refr_overflow (refr_overflow)
  );

  refr_row_track u_row_track (
    .clk      (clk),
    .rst      (rst),
    .prefr    (prefr),
    .prfbadr  (prfbadr),
    .mem_refr (mem_refr)
  );

endmodule

/* sim/tb_refr_checker.sv */
`timescale 1ns/1ps
`include "refr_macros.svh"

module tb_refr_checker (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [127:0]             test_name,
  input  logic                     pref,
  input  refr_pkg::acc_req_t       acc1_req,
  input  logic                     acc1_valid,
  input  logic                     acc1_ready,
  input  refr_pkg::acc_req_t       acc2_req,
  input  logic                     acc2_valid,
  input  logic                     acc2_ready,
  input  refr_pkg::mem_acc_t       mem_acc1,
  input  refr_pkg::mem_acc_t       mem_acc2,
  input  refr_pkg::refr_cmd_t      mem_refr,
  input  logic                     refr_overflow,
  output int                       err_cnt,
  output int                       drop_cnt,
  output logic                     busy,
  output logic [`REFR_BITRBNK-1:0] next_bank
);

  import refr_pkg::*;

  int                       cyc;
  int                       pref_cyc [`REFR_NUMRBNK];
  logic                     s0_busy;
  logic                     s1_busy;
  logic [`REFR_BITRBNK-1:0] s0_bank;
  logic [`REFR_BITRBNK-1:0] s1_bank;
  logic [`REFR_BITRBNK-1:0] ptr;
  logic [`REFR_BITRROW-1:0] rows [`REFR_NUMRBNK];
  refr_cmd_t                exp_refr;
  mem_acc_t                 exp_acc1;
  mem_acc_t                 exp_acc2;
  mem_acc_t                 prev_acc1;
  mem_acc_t                 prev_acc2;

  task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("MISMATCH %0s %0s expected %0h actual %0h", test_name, what, exp, act);
    err_cnt++;
  endtask

  task automatic check_acc(input string what, input mem_acc_t exp, input mem_acc_t act);
    if (act.valid !== exp.valid || (exp.valid && act.req !== exp.req)) begin
      mismatch(what, exp, act);
    end
  endtask

  function automatic logic hits_bank(input mem_acc_t a, input logic [`REFR_BITRBNK-1:0] b);
    return a.valid && (a.req.bank == b);
  endfunction

  // ------------------------------------------------------------------------
  // port checks and one step of the two-stage refresh model
  // ------------------------------------------------------------------------

  always @(posedge clk) begin : model
    logic hit;
    logic exp_pref;
    if (rst) begin
      cyc       = 0;
      err_cnt   = 0;
      drop_cnt  = 0;
      s0_busy   = 1'b0;
      s1_busy   = 1'b0;
      s0_bank   = '0;
      s1_bank   = '0;
      ptr       = '0;
      exp_refr  = '0;
      exp_acc1  = '0;
      exp_acc2  = '0;
      prev_acc1 = '0;
      prev_acc2 = '0;
      busy      = 1'b0;
      next_bank = '0;
      for (int b = 0; b < `REFR_NUMRBNK; b++) begin
        rows[b]     = '0;
        pref_cyc[b] = 0;
      end
    end else begin
      cyc++;
      exp_pref = (cyc % `REFR_REFFREQ == 0);
      if (pref !== exp_pref) begin
        mismatch("pref", exp_pref, pref);
      end
      if (acc1_ready !== !exp_pref || acc2_ready !== !exp_pref) begin
        mismatch("ready", {!exp_pref, !exp_pref}, {acc2_ready, acc1_ready});
      end
      check_acc("mem_acc1", exp_acc1, mem_acc1);
      check_acc("mem_acc2", exp_acc2, mem_acc2);
      if (mem_refr.valid !== exp_refr.valid || (exp_refr.valid && mem_refr !== exp_refr)) begin
        mismatch("mem_refr", exp_refr, mem_refr);
      end
      if (mem_refr.valid === 1'b1) begin
        if (hits_bank(prev_acc1, mem_refr.bank) || hits_bank(prev_acc2, mem_refr.bank)) begin
          $display("%0s: refresh of bank %0d follows an access to the same bank",
                   test_name, mem_refr.bank);
          err_cnt++;
        end
        if (cyc - pref_cyc[mem_refr.bank] < 3) begin
          $display("%0s: refresh of bank %0d came only %0d cycles after its pref",
                   test_name, mem_refr.bank, cyc - pref_cyc[mem_refr.bank]);
          err_cnt++;
        end
      end
      if (refr_overflow !== (drop_cnt > 0)) begin
        mismatch("refr_overflow", (drop_cnt > 0), refr_overflow);
      end

      // stage 1 issues unless a registered access holds its bank.
      hit = hits_bank(mem_acc1, s1_bank) || hits_bank(mem_acc2, s1_bank);
      exp_refr.valid = s1_busy && !hit;
      if (s1_busy && !hit) begin
        exp_refr.bank  = s1_bank;
        exp_refr.row   = rows[s1_bank];
        rows[s1_bank]  = `REFR_BITRROW'((rows[s1_bank] + 1) % `REFR_NUMRROW);
        s1_busy        = 1'b0;
      end
      if (s0_busy && !s1_busy) begin
        s1_busy = 1'b1;
        s1_bank = s0_bank;
        s0_busy = 1'b0;
      end
      if (pref) begin
        pref_cyc[ptr] = cyc;
        if (s0_busy) begin
          drop_cnt++;
        end else begin
          s0_busy = 1'b1;
          s0_bank = ptr;
        end
        ptr = `REFR_BITRBNK'((ptr + 1) % `REFR_NUMRBNK);
      end
      busy      = s0_busy || s1_busy;
      next_bank = s1_busy ? s1_bank : (s0_busy ? s0_bank : ptr);
      prev_acc1 = mem_acc1;
      prev_acc2 = mem_acc2;
      exp_acc1  = '{valid: acc1_valid && !exp_pref, req: acc1_req};
      exp_acc2  = '{valid: acc2_valid && !exp_pref, req: acc2_req};
    end
  end

endmodule

/* sim/tb_refr_top.sv */
`timescale 1ns/1ps
`include "refr_macros.svh"

module tb_refr_top;

  import refr_pkg::*;

  typedef enum logic [1:0] {BANK_FIXED, BANK_RANDOM, BANK_COLLIDE} bank_mode_t;

  typedef struct {
    logic [127:0]             name;
    int                       cycles;
    logic [1:0]               mask;
    bank_mode_t               mode;
    logic [`REFR_BITRBNK-1:0] bank;
    logic                     ovf;
  } test_row_t;

  localparam int NTEST         = 5;
  localparam int READY_TIMEOUT = 3;
  localparam int DRAIN_TIMEOUT = 4 * `REFR_REFFREQ;

  logic                     clk;
  logic                     rst;
  acc_req_t                 acc1_req;
  acc_req_t                 acc2_req;
  logic                     acc1_valid;
  logic                     acc2_valid;
  logic                     acc1_ready;
  logic                     acc2_ready;
  logic                     pref;
  mem_acc_t                 mem_acc1;
  mem_acc_t                 mem_acc2;
  refr_cmd_t                mem_refr;
  logic                     refr_overflow;
  logic [127:0]             cur_name;
  int                       err_cnt;
  int                       drop_cnt;
  logic                     busy;
  logic [`REFR_BITRBNK-1:0] next_bank;
  logic [31:0]              lfsr;
  int                       fail_tests;
  test_row_t                tests [NTEST];

  refr_top DUT (
    .clk           (clk),
    .rst           (rst),
    .acc1_req      (acc1_req),
    .acc1_valid    (acc1_valid),
    .acc1_ready    (acc1_ready),
    .acc2_req      (acc2_req),
    .acc2_valid    (acc2_valid),
    .acc2_ready    (acc2_ready),
    .pref          (pref),
    .mem_acc1      (mem_acc1),
    .mem_acc2      (mem_acc2),
    .mem_refr      (mem_refr),
    .refr_overflow (refr_overflow)
  );

  tb_refr_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .test_name     (cur_name),
    .pref          (pref),
    .acc1_req      (acc1_req),
    .acc1_valid    (acc1_valid),
    .acc1_ready    (acc1_ready),
    .acc2_req      (acc2_req),
    .acc2_valid    (acc2_valid),
    .acc2_ready    (acc2_ready),
    .mem_acc1      (mem_acc1),
    .mem_acc2      (mem_acc2),
    .mem_refr      (mem_refr),
    .refr_overflow (refr_overflow),
    .err_cnt       (err_cnt),
    .drop_cnt      (drop_cnt),
    .busy          (busy),
    .next_bank     (next_bank)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1, shifting right.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  task automatic pick_request(input test_row_t t, output acc_req_t r);
    case (t.mode)
      BANK_FIXED:  r.bank = t.bank;
      BANK_RANDOM: r.bank = `REFR_BITRBNK'(take_bits(`REFR_BITRBNK));
      default:     r.bank = next_bank;
    endcase
    r.row = `REFR_BITRROW'(take_bits(`REFR_BITRROW));
    r.op  = acc_op_t'(take_bits(1));
  endtask

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------

  task automatic run_test(input test_row_t t, output logic stuck);
    int waited;
    stuck = 1'b0;
    for (int c = 0; c < t.cycles && !stuck; c++) begin
      @(negedge clk);
      pick_request(t, acc1_req);
      pick_request(t, acc2_req);
      acc1_valid = t.mask[0];
      acc2_valid = t.mask[1];
      waited = 0;
      while (!(acc1_ready && acc2_ready) && !stuck) begin
        @(negedge clk);
        waited++;
        if (waited > READY_TIMEOUT) begin
          stuck = 1'b1;
        end
      end
    end
    @(negedge clk);
    acc1_valid = 1'b0;
    acc2_valid = 1'b0;
  endtask

  task automatic wait_drain(output logic late);
    int waited;
    waited = 0;
    @(negedge clk);
    while (busy && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    late = busy;
    repeat (2) @(negedge clk);
  endtask

  initial begin
    int   err_before;
    logic stuck;
    logic late;
    logic ok;
    lfsr       = 32'd88522;
    rst        = 1'b1;
    acc1_req   = '0;
    acc2_req   = '0;
    acc1_valid = 1'b0;
    acc2_valid = 1'b0;
    cur_name   = '0;
    fail_tests = 0;
    tests[0] = '{"pref_idle", 60, 2'b00, BANK_FIXED, 3'd0, 1'b0};
    tests[1] = '{"acc_fixed", 40, 2'b11, BANK_FIXED, 3'd5, 1'b0};
    tests[2] = '{"row_wrap", 2600, 2'b00, BANK_FIXED, 3'd0, 1'b0};
    tests[3] = '{"rand_both", 400, 2'b11, BANK_RANDOM, 3'd0, 1'b0};
    // the dead access cycle after each pulse lets stage 1 issue, so a held
    // collision delays refreshes but never backs the pipeline up to a drop.
    tests[4] = '{"collide_hold", 40, 2'b11, BANK_COLLIDE, 3'd0, 1'b0};
    repeat (5) @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < NTEST; i++) begin
      cur_name   = tests[i].name;
      err_before = err_cnt;
      run_test(tests[i], stuck);
      wait_drain(late);
      ok = 1'b0;
      if (stuck) begin
        $display("%0s: ready stayed low for more than %0d cycles", cur_name, READY_TIMEOUT);
      end else if (late) begin
        $display("%0s: refresh requests still pending after %0d cycles", cur_name,
                 DRAIN_TIMEOUT);
      end else if (refr_overflow !== tests[i].ovf) begin
        $display("MISMATCH %0s refr_overflow expected %0b actual %0b", cur_name,
                 tests[i].ovf, refr_overflow);
      end else if (err_cnt != err_before) begin
        $display("FAIL %0s with %0d checker errors", cur_name, err_cnt - err_before);
      end else begin
        ok = 1'b1;
        $display("PASS %0s", cur_name);
      end
      if (!ok) begin
        fail_tests++;
      end
    end

    $display("tests %0d passed %0d failed %0d checker errors %0d dropped refreshes %0d",
             NTEST, NTEST - fail_tests, fail_tests, err_cnt, drop_cnt);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+verilog
verilog/refr_pkg.sv
verilog/refr_tick_gen.sv
verilog/refr_access_gate.sv
verilog/refr_sched.sv
verilog/refr_row_track.sv
verilog/refr_top.sv
sim/tb_refr_checker.sv
sim/tb_refr_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_refr_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
